// ==== build.f ====
+incdir+.
rv_isa_pkg.sv
id_ctrl_pkg.sv
id_decode_if.sv
id_decoder.sv
id_operand_fwd.sv
id_ex_reg.sv
id_stage.sv
id_assertions.sv
tb_id_stage.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run tb_id_stage and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_id_stage -Mdir obj_dir
	./obj_dir/Vtb_id_stage | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "id_defines.svh"

module tb_id_stage;
  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  localparam int num_tests    = 2000;
  localparam int reset_cycles = 16;
  localparam int timeout_ns   = num_tests * 20 + 2000;

  typedef struct packed {
    alu_op_e     op;
    inst_class_e cls;
    xlen_t       op1;
    xlen_t       op2;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic        rd1;
    logic        rd2;
    reg_addr_t   rd;
    logic        rd_we;
    mem_off_t    off;
    funct3_t     sel;
    logic        stall;
    logic        flush;
    xlen_t       target;
  } expect_t;

  logic        clk = 1'b0;
  logic        rst_i;
  inst_t       inst_i;
  xlen_t       pc_i;
  xlen_t       rs1_data_i;
  xlen_t       rs2_data_i;
  logic        ex_rd_we_i;
  reg_addr_t   ex_rd_addr_i;
  xlen_t       ex_rd_data_i;
  logic        ex_is_load_i;
  logic        mem_rd_we_i;
  reg_addr_t   mem_rd_addr_i;
  xlen_t       mem_rd_data_i;
  logic        wb_rd_we_i;
  reg_addr_t   wb_rd_addr_i;
  reg_addr_t   rs1_addr_o;
  reg_addr_t   rs2_addr_o;
  logic        rs1_read_o;
  logic        rs2_read_o;
  logic        stall_o;
  logic        flush_o;
  xlen_t       jalr_target_o;
  alu_op_e     op_o;
  inst_class_e class_o;
  xlen_t       op1_o;
  xlen_t       op2_o;
  logic        rd_we_o;
  reg_addr_t   rd_addr_o;
  mem_off_t    mem_off_o;
  funct3_t     mem_sel_o;

  integer  seed;
  int      errors = 0;
  int      checks = 0;
  logic    done = 1'b0;
  expect_t now_exp;
  // what the id/ex register must hold after the next edge
  expect_t held = '0;

  id_stage uut (.*);

  bind id_stage id_assertions u_assertions (
    .clk     (clk),
    .rst_i   (rst_i),
    .stall_o (stall_o),
    .flush_o (flush_o),
    .op_o    (op_o),
    .class_o (class_o),
    .rd_we_o (rd_we_o)
  );

  always #10 clk = ~clk;

  function automatic alu_op_e int_op(funct3_t f3);
    case (f3)
      3'd0:    return alu_add;
      3'd1:    return alu_sll;
      3'd2:    return alu_slt;
      3'd3:    return alu_sltu;
      3'd4:    return alu_xor;
      3'd5:    return alu_srl;
      3'd6:    return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic alu_op_e word_op(funct3_t f3, logic [6:0] f7);
    case ({f7, f3})
      {7'h00, 3'd0}: return alu_addw;
      {7'h20, 3'd0}: return alu_subw;
      {7'h00, 3'd1}: return alu_sllw;
      {7'h00, 3'd5}: return alu_srlw;
      {7'h20, 3'd5}: return alu_sraw;
      default:       return alu_nop;
    endcase
  endfunction

  function automatic alu_op_e branch_op(funct3_t f3);
    case (f3)
      3'd0:    return alu_beq;
      3'd1:    return alu_bne;
      3'd4:    return alu_blt;
      3'd5:    return alu_bge;
      3'd6:    return alu_bltu;
      3'd7:    return alu_bgeu;
      default: return alu_nop;
    endcase
  endfunction

  // youngest in-flight write wins over the register file
  function automatic xlen_t bypass(reg_addr_t r, xlen_t rf_val);
    return (ex_rd_we_i && ex_rd_addr_i == r) ? ex_rd_data_i :
           ((mem_rd_we_i && mem_rd_addr_i == r) ? mem_rd_data_i : rf_val);
  endfunction

  function automatic expect_t ref_decode();
    expect_t     e;
    alu_op_e     op;
    inst_class_e cls;
    funct3_t     f3;
    logic [6:0]  f7;
    xlen_t       imm_i;
    xlen_t       imm;
    logic        redirect;
    e = '0;
    op = alu_nop;
    cls = cls_none;
    f3 = inst_i[14:12];
    f7 = inst_i[31:25];
    imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
    imm = '0;
    if (inst_i[1:0] == 2'b11) begin
      case (inst_i[6:2])
        5'b01100: begin
          cls = cls_alu_reg;
          op = (f7 == 7'h00) ? int_op(f3) :
               (f7 == 7'h20 && f3 == 3'd0) ? alu_sub :
               (f7 == 7'h20 && f3 == 3'd5) ? alu_sra : alu_nop;
        end
        5'b00100: begin
          cls = cls_alu_imm;
          imm = imm_i;
          if (f3 == 3'd1 || f3 == 3'd5) begin
            // six-bit shamt with bit 30 picking arithmetic
            op = (inst_i[31:26] == 6'h00) ? int_op(f3) :
                 (inst_i[31:26] == 6'h10 && f3 == 3'd5) ? alu_sra : alu_nop;
          end else begin
            op = int_op(f3);
          end
        end
        5'b01110: begin
          cls = cls_alu_reg_w;
          op = word_op(f3, f7);
        end
        5'b00110: begin
          cls = cls_alu_imm_w;
          imm = imm_i;
          op = (f3 == 3'd0) ? alu_addw : word_op(f3, f7);
        end
        5'b11000: begin
          cls = cls_branch;
          op = branch_op(f3);
        end
        5'b00000: begin
          cls = cls_load;
          imm = imm_i;
          op = (f3 != 3'd7) ? alu_add : alu_nop;
        end
        5'b01000: begin
          cls = cls_store;
          imm = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
          op = !f3[2] ? alu_add : alu_nop;
        end
        5'b01101, 5'b00101: begin
          cls = cls_upper;
          imm = {{44{inst_i[31]}}, inst_i[31:12]};
          op = (inst_i[6:2] == 5'b00101) ? alu_auipc : alu_lui;
        end
        5'b11011: begin
          cls = cls_jump;
          imm = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
          op = alu_jal;
        end
        5'b11001: begin
          cls = cls_jump;
          imm = imm_i;
          op = (f3 == 3'd0) ? alu_jalr : alu_nop;
        end
        default: begin
          op = alu_nop;
        end
      endcase
    end
    if (op == alu_nop) begin
      cls = cls_none;
      imm = '0;
    end
    e.op = op;
    e.cls = cls;
    e.rd1 = (cls inside {cls_alu_reg, cls_alu_imm, cls_alu_reg_w, cls_alu_imm_w, cls_branch,
                         cls_load, cls_store}) || (op == alu_jalr);
    e.rd2 = cls inside {cls_alu_reg, cls_alu_reg_w, cls_branch, cls_store};
    e.rs1 = e.rd1 ? inst_i[19:15] : 5'd0;
    e.rs2 = e.rd2 ? inst_i[24:20] : 5'd0;
    e.rd_we = (inst_i[11:7] != 5'd0) && !(cls inside {cls_none, cls_branch, cls_store});
    e.rd = e.rd_we ? inst_i[11:7] : 5'd0;
    e.off = (cls == cls_load || cls == cls_store) ? imm[11:0] : 12'h000;
    e.sel = (cls == cls_none) ? 3'd0 : f3;
    e.op1 = e.rd1 ? bypass(e.rs1, rs1_data_i) :
            ((op == alu_auipc || op == alu_jal) ? pc_i : '0);
    if (e.rd2) begin
      e.op2 = bypass(e.rs2, rs2_data_i);
    end else if (cls inside {cls_alu_imm, cls_alu_imm_w, cls_load, cls_upper}) begin
      e.op2 = imm;
    end else begin
      e.op2 = (cls == cls_jump) ? pc_i : '0;
    end
    e.stall = !rst_i && ex_is_load_i && ((e.rd1 && e.rs1 == ex_rd_addr_i) ||
                                         (e.rd2 && e.rs2 == ex_rd_addr_i));
    redirect = (op == alu_jalr) &&
               ((ex_rd_we_i && ex_rd_addr_i == e.rs1) ||
                (mem_rd_we_i && mem_rd_addr_i == e.rs1) ||
                (wb_rd_we_i && wb_rd_addr_i == e.rs1));
    e.flush = !rst_i && redirect;
    e.target = redirect ? ((e.op1 + imm) & ~64'h1) : '0;
    return e;
  endfunction

  task automatic check_op(input string what, input alu_op_e got, input alu_op_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_class(input string what, input inst_class_e got, input inst_class_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_off(input string what, input mem_off_t got, input mem_off_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sel(input string what, input funct3_t got, input funct3_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  function automatic logic [4:0] major_opcode(int unsigned kind);
    case (kind)
      0:       return 5'b01100;
      1:       return 5'b00100;
      2:       return 5'b01110;
      3:       return 5'b00110;
      4:       return 5'b11000;
      5:       return 5'b00000;
      6:       return 5'b01000;
      7:       return 5'b01101;
      8:       return 5'b00101;
      9:       return 5'b11011;
      default: return 5'b11001;
    endcase
  endfunction

  task automatic drive_random();
    inst_t       w;
    int unsigned pick;
    reg_addr_t   a;
    logic        we;
    w = $random(seed);
    pick = {$random(seed)} % 12;
    w[11:7] = 5'({$random(seed)} % 8);
    if (pick != 7 && pick != 8 && pick != 9) begin
      // few register numbers make bypass matches common
      w[19:15] = 5'({$random(seed)} % 8);
      w[24:20] = 5'({$random(seed)} % 8);
    end
    if (pick == 0 || pick == 2 || pick == 3) begin
      case ({$random(seed)} % 4)
        0:       w[31:25] = 7'h00;
        1:       w[31:25] = 7'h20;
        // m extension
        2:       w[31:25] = 7'h01;
        default: w[31:25] = w[31:25];
      endcase
    end
    if (pick == 1 && (w[14:12] == 3'd1 || w[14:12] == 3'd5) && ({$random(seed)} % 4 != 0)) begin
      w[31:26] = ({$random(seed)} % 2 == 1) ? 6'h10 : 6'h00;
    end
    if (pick == 10 && ({$random(seed)} % 4 != 0)) begin
      w[14:12] = 3'd0;
    end
    if (pick < 11) begin
      w[6:0] = {major_opcode(pick), 2'b11};
    end
    inst_i <= w;
    pc_i <= {$random(seed), $random(seed)} & ~64'h3;
    rs1_data_i <= {$random(seed), $random(seed)};
    rs2_data_i <= {$random(seed), $random(seed)};
    a = 5'({$random(seed)} % 8);
    we = (a != 5'd0) && ({$random(seed)} % 2 == 1);
    ex_rd_addr_i <= a;
    ex_rd_we_i <= we;
    ex_is_load_i <= we && ({$random(seed)} % 3 == 0);
    ex_rd_data_i <= {$random(seed), $random(seed)};
    a = 5'({$random(seed)} % 8);
    mem_rd_addr_i <= a;
    mem_rd_we_i <= (a != 5'd0) && ({$random(seed)} % 2 == 1);
    mem_rd_data_i <= {$random(seed), $random(seed)};
    a = 5'({$random(seed)} % 8);
    wb_rd_addr_i <= a;
    wb_rd_we_i <= (a != 5'd0) && ({$random(seed)} % 2 == 1);
  endtask

  // decode keeps its instruction while the load moves on to mem
  task automatic drive_hold();
    mem_rd_we_i <= ex_rd_we_i;
    mem_rd_addr_i <= ex_rd_addr_i;
    mem_rd_data_i <= {$random(seed), $random(seed)};
    wb_rd_we_i <= mem_rd_we_i;
    wb_rd_addr_i <= mem_rd_addr_i;
    ex_rd_we_i <= 1'b0;
    ex_is_load_i <= 1'b0;
  endtask

  initial begin
    seed = 19;
    rst_i <= 1'b1;
    inst_i <= '0;
    pc_i <= '0;
    rs1_data_i <= '0;
    rs2_data_i <= '0;
    ex_rd_we_i <= 1'b0;
    ex_rd_addr_i <= '0;
    ex_rd_data_i <= '0;
    ex_is_load_i <= 1'b0;
    mem_rd_we_i <= 1'b0;
    mem_rd_addr_i <= '0;
    mem_rd_data_i <= '0;
    wb_rd_we_i <= 1'b0;
    wb_rd_addr_i <= '0;
    for (int n = 0; n < reset_cycles + num_tests; n++) begin
      @(posedge clk);
      if (n == reset_cycles - 1) begin
        rst_i <= 1'b0;
      end
      if (stall_o) begin
        drive_hold();
      end else begin
        drive_random();
      end
    end
    repeat (2) @(posedge clk);
    done = 1'b1;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  always @(negedge clk) begin
    if (!done) begin
      now_exp = ref_decode();
      check_addr("rs1_addr_o", rs1_addr_o, now_exp.rs1);
      check_addr("rs2_addr_o", rs2_addr_o, now_exp.rs2);
      check_bit("rs1_read_o", rs1_read_o, now_exp.rd1);
      check_bit("rs2_read_o", rs2_read_o, now_exp.rd2);
      check_bit("stall_o", stall_o, now_exp.stall);
      check_bit("flush_o", flush_o, now_exp.flush);
      check_word("jalr_target_o", jalr_target_o, now_exp.target);
      // registered outputs belong to the previous cycle
      check_op("op_o", op_o, held.op);
      check_class("class_o", class_o, held.cls);
      check_word("op1_o", op1_o, held.op1);
      check_word("op2_o", op2_o, held.op2);
      check_bit("rd_we_o", rd_we_o, held.rd_we);
      check_addr("rd_addr_o", rd_addr_o, held.rd);
      check_off("mem_off_o", mem_off_o, held.off);
      check_sel("mem_sel_o", mem_sel_o, held.sel);
      if (rst_i || now_exp.stall || now_exp.flush) begin
        held = '0;
      end else begin
        held = now_exp;
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("run did not finish within %0d ns, the watchdog stopped it", timeout_ns);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== id_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_assertions (
  input wire logic                     clk,
  input wire logic                     rst_i,
  input wire logic                     stall_o,
  input wire logic                     flush_o,
  input wire id_ctrl_pkg::alu_op_e     op_o,
  input wire id_ctrl_pkg::inst_class_e class_o,
  input wire logic                     rd_we_o
);
  import id_ctrl_pkg::*;

  // no hazard request while held in reset
  quiet_in_reset: assert property (@(posedge clk) rst_i |-> (!stall_o && !flush_o))
    else $error("stall or flush raised during reset");

  // held or squashed instruction leaves a bubble at id/ex
  bubble_after_hazard: assert property (@(posedge clk)
    (rst_i || stall_o || flush_o) |=> (op_o == alu_nop && class_o == cls_none && !rd_we_o))
    else $error("id/ex register did not load a bubble");

  nop_never_writes: assert property (@(posedge clk) disable iff (rst_i)
    (op_o == alu_nop) |-> !rd_we_o)
    else $error("register write enabled for a nop in id/ex");

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  wire logic                  clk,
  input  wire logic                  rst_i,
  input  wire rv_isa_pkg::inst_t     inst_i,
  input  wire rv_isa_pkg::xlen_t     pc_i,
  input  wire rv_isa_pkg::xlen_t     rs1_data_i,
  input  wire rv_isa_pkg::xlen_t     rs2_data_i,
  input  wire logic                  ex_rd_we_i,
  input  wire rv_isa_pkg::reg_addr_t ex_rd_addr_i,
  input  wire rv_isa_pkg::xlen_t     ex_rd_data_i,
  input  wire logic                  ex_is_load_i,
  input  wire logic                  mem_rd_we_i,
  input  wire rv_isa_pkg::reg_addr_t mem_rd_addr_i,
  input  wire rv_isa_pkg::xlen_t     mem_rd_data_i,
  input  wire logic                  wb_rd_we_i,
  input  wire rv_isa_pkg::reg_addr_t wb_rd_addr_i,
  output rv_isa_pkg::reg_addr_t      rs1_addr_o,
  output rv_isa_pkg::reg_addr_t      rs2_addr_o,
  output logic                       rs1_read_o,
  output logic                       rs2_read_o,
  output logic                       stall_o,
  output logic                       flush_o,
  output rv_isa_pkg::xlen_t          jalr_target_o,
  output id_ctrl_pkg::alu_op_e       op_o,
  output id_ctrl_pkg::inst_class_e   class_o,
  output rv_isa_pkg::xlen_t          op1_o,
  output rv_isa_pkg::xlen_t          op2_o,
  output logic                       rd_we_o,
  output rv_isa_pkg::reg_addr_t      rd_addr_o,
  output rv_isa_pkg::mem_off_t       mem_off_o,
  output rv_isa_pkg::funct3_t        mem_sel_o
);
  import rv_isa_pkg::*;

  // operands before the id/ex boundary
  xlen_t op1_id;
  xlen_t op2_id;

  decode_if dec_if ();

  id_decoder u_decoder (
    .inst_i (inst_i),
    .dec    (dec_if)
  );

  id_operand_fwd u_operand_fwd (
    .rst_i         (rst_i),
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .ex_rd_we_i    (ex_rd_we_i),
    .ex_rd_addr_i  (ex_rd_addr_i),
    .ex_rd_data_i  (ex_rd_data_i),
    .ex_is_load_i  (ex_is_load_i),
    .mem_rd_we_i   (mem_rd_we_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_i (mem_rd_data_i),
    .wb_rd_we_i    (wb_rd_we_i),
    .wb_rd_addr_i  (wb_rd_addr_i),
    .opnd          (dec_if),
    .rs1_addr_o    (rs1_addr_o),
    .rs2_addr_o    (rs2_addr_o),
    .rs1_read_o    (rs1_read_o),
    .rs2_read_o    (rs2_read_o),
    .op1_o         (op1_id),
    .op2_o         (op2_id),
    .stall_o       (stall_o),
    .flush_o       (flush_o),
    .jalr_target_o (jalr_target_o)
  );

  id_ex_reg u_id_ex_reg (
    .clk       (clk),
    .rst_i     (rst_i),
    .pipe      (dec_if),
    .op1_i     (op1_id),
    .op2_i     (op2_id),
    .stall_i   (stall_o),
    .flush_i   (flush_o),
    .op_o      (op_o),
    .class_o   (class_o),
    .op1_o     (op1_o),
    .op2_o     (op2_o),
    .rd_we_o   (rd_we_o),
    .rd_addr_o (rd_addr_o),
    .mem_off_o (mem_off_o),
    .mem_sel_o (mem_sel_o)
  );

endmodule

`default_nettype wire

// ==== id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "id_defines.svh"

module id_ex_reg (
  input  wire logic                   clk,
  input  wire logic                   rst_i,
  decode_if.pipe                      pipe,
  input  wire rv_isa_pkg::xlen_t      op1_i,
  input  wire rv_isa_pkg::xlen_t      op2_i,
  input  wire logic                   stall_i,
  input  wire logic                   flush_i,
  output id_ctrl_pkg::alu_op_e        op_o,
  output id_ctrl_pkg::inst_class_e    class_o,
  output rv_isa_pkg::xlen_t           op1_o,
  output rv_isa_pkg::xlen_t           op2_o,
  output logic                        rd_we_o,
  output rv_isa_pkg::reg_addr_t       rd_addr_o,
  output rv_isa_pkg::mem_off_t        mem_off_o,
  output rv_isa_pkg::funct3_t         mem_sel_o
);
  import id_ctrl_pkg::*;

  logic bubble;

  // held or squashed instruction must not reach execute
  assign bubble = rst_i || stall_i || flush_i;

  always_ff @(posedge clk) begin
    if (bubble) begin
      op_o      <= alu_nop;
      class_o   <= cls_none;
      op1_o     <= `ZERO_WORD;
      op2_o     <= `ZERO_WORD;
      rd_we_o   <= 1'b0;
      rd_addr_o <= `ZERO_ADDR;
      mem_off_o <= 12'h000;
      mem_sel_o <= 3'b000;
    end else begin
      op_o      <= pipe.op;
      class_o   <= pipe.iclass;
      op1_o     <= op1_i;
      op2_o     <= op2_i;
      rd_we_o   <= pipe.rd_we;
      rd_addr_o <= pipe.rd;
      mem_off_o <= pipe.mem_off;
      // funct3 selects width and sign for loads and stores
      mem_sel_o <= pipe.funct3;
    end
  end

endmodule

`default_nettype wire

// ==== id_operand_fwd.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "id_defines.svh"

module id_operand_fwd (
  input  wire logic                  rst_i,
  input  wire rv_isa_pkg::xlen_t     pc_i,
  input  wire rv_isa_pkg::xlen_t     rs1_data_i,
  input  wire rv_isa_pkg::xlen_t     rs2_data_i,
  input  wire logic                  ex_rd_we_i,
  input  wire rv_isa_pkg::reg_addr_t ex_rd_addr_i,
  input  wire rv_isa_pkg::xlen_t     ex_rd_data_i,
  input  wire logic                  ex_is_load_i,
  input  wire logic                  mem_rd_we_i,
  input  wire rv_isa_pkg::reg_addr_t mem_rd_addr_i,
  input  wire rv_isa_pkg::xlen_t     mem_rd_data_i,
  input  wire logic                  wb_rd_we_i,
  input  wire rv_isa_pkg::reg_addr_t wb_rd_addr_i,
  decode_if.opnd                     opnd,
  output rv_isa_pkg::reg_addr_t      rs1_addr_o,
  output rv_isa_pkg::reg_addr_t      rs2_addr_o,
  output logic                       rs1_read_o,
  output logic                       rs2_read_o,
  output rv_isa_pkg::xlen_t          op1_o,
  output rv_isa_pkg::xlen_t          op2_o,
  output logic                       stall_o,
  output logic                       flush_o,
  output rv_isa_pkg::xlen_t          jalr_target_o
);
  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  logic  ex_hit1;
  logic  mem_hit1;
  logic  wb_hit1;
  logic  ex_hit2;
  logic  mem_hit2;
  logic  load_use;
  logic  jalr_redirect;
  xlen_t jalr_sum;

  assign rs1_addr_o = opnd.rs1;
  assign rs2_addr_o = opnd.rs2;
  assign rs1_read_o = opnd.rs1_rd;
  assign rs2_read_o = opnd.rs2_rd;

  assign ex_hit1  = ex_rd_we_i && (ex_rd_addr_i == opnd.rs1);
  assign mem_hit1 = mem_rd_we_i && (mem_rd_addr_i == opnd.rs1);
  assign wb_hit1  = wb_rd_we_i && (wb_rd_addr_i == opnd.rs1);
  assign ex_hit2  = ex_rd_we_i && (ex_rd_addr_i == opnd.rs2);
  assign mem_hit2 = mem_rd_we_i && (mem_rd_addr_i == opnd.rs2);

  // youngest producer wins
  always_comb begin
    if (opnd.rs1_rd) begin
      op1_o = ex_hit1 ? ex_rd_data_i : (mem_hit1 ? mem_rd_data_i : rs1_data_i);
    end else if (opnd.op == alu_auipc || opnd.op == alu_jal) begin
      op1_o = pc_i;
    end else begin
      op1_o = `ZERO_WORD;
    end
  end

  always_comb begin
    if (opnd.rs2_rd) begin
      op2_o = ex_hit2 ? ex_rd_data_i : (mem_hit2 ? mem_rd_data_i : rs2_data_i);
    end else if (opnd.iclass inside {cls_alu_imm, cls_alu_imm_w, cls_load, cls_upper}) begin
      op2_o = opnd.imm;
    end else if (opnd.iclass == cls_jump) begin
      // link value source
      op2_o = pc_i;
    end else begin
      op2_o = `ZERO_WORD;
    end
  end

  // load data not ready until mem, hold decode one cycle
  assign load_use = ex_is_load_i &&
                    ((opnd.rs1_rd && opnd.rs1 == ex_rd_addr_i) ||
                     (opnd.rs2_rd && opnd.rs2 == ex_rd_addr_i));
  assign stall_o  = !rst_i && load_use;

  // fetch predicted with a stale base, redirect when it is still in flight
  assign jalr_sum      = op1_o + opnd.imm;
  assign jalr_redirect = (opnd.op == alu_jalr) && (ex_hit1 || mem_hit1 || wb_hit1);
  assign flush_o       = !rst_i && jalr_redirect;
  assign jalr_target_o = jalr_redirect ? {jalr_sum[`XLEN-1:1], 1'b0} : `ZERO_WORD;

endmodule

`default_nettype wire

// ==== id_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "id_defines.svh"

module id_decoder (
  input wire rv_isa_pkg::inst_t inst_i,
  decode_if.dec                 dec
);
  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  major_op_e   opc;
  funct3_t     funct3;
  funct7_t     funct7;
  reg_addr_t   rd;
  xlen_t       imm_i;
  xlen_t       imm_s;
  xlen_t       imm_u;
  xlen_t       imm_j;
  xlen_t       imm;
  logic        f7_ok;
  logic        shamt_ok;
  logic        is_shift;
  logic        rs1_rd;
  logic        rs2_rd;
  logic        rd_we;
  alu_op_e     op;
  inst_class_e iclass;

  function automatic alu_op_e base_op(funct3_t f3, logic sub_en, logic sra_en);
    case (f3)
      f3_add:  return sub_en ? alu_sub : alu_add;
      f3_sll:  return alu_sll;
      f3_slt:  return alu_slt;
      f3_sltu: return alu_sltu;
      f3_xor:  return alu_xor;
      f3_sr:   return sra_en ? alu_sra : alu_srl;
      f3_or:   return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic alu_op_e word_op(funct3_t f3, logic sub_en, logic sra_en);
    case (f3)
      f3_add:  return sub_en ? alu_subw : alu_addw;
      f3_sll:  return alu_sllw;
      f3_sr:   return sra_en ? alu_sraw : alu_srlw;
      default: return alu_nop;
    endcase
  endfunction

  assign opc    = major_op_e'(inst_i[6:2]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rd     = inst_i[11:7];

  assign imm_i = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{(`XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  // upper 20 bits unshifted, execute places them
  assign imm_u = {{(`XLEN-20){inst_i[31]}}, inst_i[31:12]};
  assign imm_j = {{(`XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};

  // m extension has funct7 = 1 and falls out here
  assign f7_ok    = (funct7 == f7_base) ||
                    (funct7 == f7_alt && (funct3 == f3_add || funct3 == f3_sr));
  assign is_shift = (funct3 == f3_sll) || (funct3 == f3_sr);
  // rv64 shamt is 6 bits wide
  assign shamt_ok = (inst_i[31:26] == 6'b000000) ||
                    (inst_i[31:26] == 6'b010000 && funct3 == f3_sr);

  always_comb begin
    op = alu_nop;
    if (inst_i[1:0] == 2'b11) begin
      case (opc)
        opc_op:       op = f7_ok ? base_op(funct3, funct7[5], funct7[5]) : alu_nop;
        opc_op_imm:   op = (is_shift && !shamt_ok) ? alu_nop : base_op(funct3, 1'b0, inst_i[30]);
        opc_op_w:     op = f7_ok ? word_op(funct3, funct7[5], funct7[5]) : alu_nop;
        opc_op_imm_w: op = (is_shift && !f7_ok) ? alu_nop : word_op(funct3, 1'b0, funct7[5]);
        opc_branch: begin
          case (funct3)
            f3_beq:  op = alu_beq;
            f3_bne:  op = alu_bne;
            f3_blt:  op = alu_blt;
            f3_bge:  op = alu_bge;
            f3_bltu: op = alu_bltu;
            f3_bgeu: op = alu_bgeu;
            default: op = alu_nop;
          endcase
        end
        // address add, funct3 111 has no load
        opc_load:     op = (funct3 != 3'b111) ? alu_add : alu_nop;
        opc_store:    op = !funct3[2] ? alu_add : alu_nop;
        opc_lui:      op = alu_lui;
        opc_auipc:    op = alu_auipc;
        opc_jal:      op = alu_jal;
        opc_jalr:     op = (funct3 == 3'b000) ? alu_jalr : alu_nop;
        default:      op = alu_nop;
      endcase
    end
  end

  always_comb begin
    case (opc)
      opc_op:              iclass = cls_alu_reg;
      opc_op_imm:          iclass = cls_alu_imm;
      opc_op_w:            iclass = cls_alu_reg_w;
      opc_op_imm_w:        iclass = cls_alu_imm_w;
      opc_branch:          iclass = cls_branch;
      opc_load:            iclass = cls_load;
      opc_store:           iclass = cls_store;
      opc_lui, opc_auipc:  iclass = cls_upper;
      opc_jal, opc_jalr:   iclass = cls_jump;
      default:             iclass = cls_none;
    endcase
    if (op == alu_nop) begin
      iclass = cls_none;
    end
  end

  always_comb begin
    case (iclass)
      cls_alu_imm, cls_alu_imm_w, cls_load: imm = imm_i;
      cls_store:                            imm = imm_s;
      cls_upper:                            imm = imm_u;
      cls_jump:                             imm = (op == alu_jalr) ? imm_i : imm_j;
      default:                              imm = `ZERO_WORD;
    endcase
  end

  assign rs1_rd = (iclass inside {cls_alu_reg, cls_alu_imm, cls_alu_reg_w, cls_alu_imm_w,
                                  cls_branch, cls_load, cls_store}) || (op == alu_jalr);
  assign rs2_rd = iclass inside {cls_alu_reg, cls_alu_reg_w, cls_branch, cls_store};
  assign rd_we  = (rd != `ZERO_ADDR) && !(iclass inside {cls_none, cls_branch, cls_store});

  assign dec.op      = op;
  assign dec.iclass  = iclass;
  assign dec.rs1_rd  = rs1_rd;
  assign dec.rs2_rd  = rs2_rd;
  assign dec.rs1     = rs1_rd ? inst_i[19:15] : `ZERO_ADDR;
  assign dec.rs2     = rs2_rd ? inst_i[24:20] : `ZERO_ADDR;
  assign dec.rd_we   = rd_we;
  assign dec.rd      = rd_we ? rd : `ZERO_ADDR;
  assign dec.imm     = imm;
  assign dec.mem_off = (iclass == cls_load || iclass == cls_store) ? imm[11:0] : 12'h000;
  assign dec.funct3  = (iclass == cls_none) ? 3'b000 : funct3;

endmodule

`default_nettype wire

// ==== id_decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  alu_op_e     op;
  inst_class_e iclass;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  logic        rs1_rd;
  logic        rs2_rd;
  reg_addr_t   rd;
  logic        rd_we;
  xlen_t       imm;
  mem_off_t    mem_off;
  // raw funct3, doubles as memory select
  funct3_t     funct3;

  modport dec (output op, iclass, rs1, rs2, rs1_rd, rs2_rd, rd, rd_we, imm, mem_off, funct3);
  modport opnd (input op, iclass, rs1, rs2, rs1_rd, rs2_rd, imm);
  modport pipe (input op, iclass, rd, rd_we, mem_off, funct3);

endinterface

`default_nettype wire

// ==== id_ctrl_pkg.sv ====
`default_nettype none

package id_ctrl_pkg;

  typedef enum logic [3:0] {
    cls_none      = 4'd0,
    cls_alu_reg   = 4'd1,
    cls_alu_imm   = 4'd2,
    cls_alu_reg_w = 4'd3,
    cls_alu_imm_w = 4'd4,
    cls_branch    = 4'd5,
    cls_load      = 4'd6,
    cls_store     = 4'd7,
    // lui and auipc
    cls_upper     = 4'd8,
    // jal and jalr
    cls_jump      = 4'd9
  } inst_class_e;

  // nop must stay zero, a bubble is all zeros
  typedef enum logic [4:0] {
    alu_nop,
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and,
    alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw,
    alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
    alu_lui, alu_auipc, alu_jal, alu_jalr
  } alu_op_e;

endpackage

`default_nettype wire

// ==== rv_isa_pkg.sv ====
`default_nettype none
`include "id_defines.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`INST_W-1:0]     inst_t;
  typedef logic [2:0]             funct3_t;
  typedef logic [6:0]             funct7_t;
  typedef logic [11:0]            mem_off_t;

  // inst[6:2], low two bits are 2'b11 for every 32-bit encoding
  typedef enum logic [4:0] {
    opc_load     = 5'b00000,
    opc_op_imm   = 5'b00100,
    opc_auipc    = 5'b00101,
    opc_op_imm_w = 5'b00110,
    opc_store    = 5'b01000,
    opc_op       = 5'b01100,
    opc_lui      = 5'b01101,
    opc_op_w     = 5'b01110,
    opc_branch   = 5'b11000,
    opc_jalr     = 5'b11001,
    opc_jal      = 5'b11011
  } major_op_e;

  // alu funct3
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // branch funct3
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  localparam funct7_t f7_base = 7'b0000000;
  // sub and sra
  localparam funct7_t f7_alt  = 7'b0100000;

endpackage

`default_nettype wire

// ==== id_defines.svh ====
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// datapath and pc width
`define XLEN 64

// register number width, 32 integer registers
`define REG_ADDR_W 5

`define INST_W 32

// reset and bubble values
`define ZERO_WORD {`XLEN{1'b0}}
`define ZERO_ADDR {`REG_ADDR_W{1'b0}}

`endif
